/* pcie_tlp_pkg.sv */
// pcie memory write packet definitions
`default_nettype none

package pcie_tlp_pkg;

   // fmt and type byte of the first header dword
   typedef enum logic [7:0]
   {
      TLP_FMT_MWR_3DW = 8'h40, // memory write, 3dw header, with data
      TLP_FMT_MWR_4DW = 8'h60  // memory write, 4dw header, with data
   } tlp_fmt_e;

   localparam logic [7:0] TLP_FIRST_LAST_BE = 8'hFF; // all bytes of first and last dword

   localparam int unsigned TLP_PAYLOAD_DW = 32; // max payload 128 bytes
   localparam int unsigned TLP_PAYLOAD_QW = TLP_PAYLOAD_DW / 2;
   localparam int unsigned TLP_BEATS = TLP_PAYLOAD_QW + 2; // header qword, addr qword, payload

   // first header qword as seen on the 64 bit tx bus
   typedef struct packed
   {
      logic [15:0] requester_id;
      logic [7:0]  tag;          // posted, always 0 here
      logic [7:0]  byte_en;      // last be, first be
      tlp_fmt_e    fmt_type;
      logic [13:0] attr;         // tc, td, ep, attr, reserved
      logic [9:0]  length;       // dwords
   } tlp_hdr0_t;

   // one beat toward the pcie core
   typedef struct packed
   {
      logic        last_half; // final beat, only the lower dword valid
      logic        last;
      logic [63:0] data;      // lower dword goes out first
   } tlp_beat_t;

endpackage

`default_nettype wire

/* hififo_dma_pkg.sv */
// dma request and buffer definitions
`default_nettype none

package hififo_dma_pkg;

   localparam int unsigned FIFO_AWIDTH = 9;
   localparam int unsigned FIFO_DEPTH = 1 << FIFO_AWIDTH; // 64 bit words

   // host write request, all units are 8 bytes
   typedef struct packed
   {
      logic [60:0] addr;      // host address in qwords
      logic [18:0] count;     // qwords, multiple of one packet
      logic        interrupt; // raise irq once the request completes
   } dma_request_t;

   // packet engine states
   typedef enum logic [1:0]
   {
      TPC_IDLE,  // waiting for data and a pending count
      TPC_OFFER, // beat 0 held until the sink takes it
      TPC_ADDR,  // beat 1 on the bus
      TPC_DATA   // beats 2 to 17, no stalls
   } tpc_state_e;

endpackage

`default_nettype wire

/* hififo_fwft_fifo.sv */
// first word fall through buffer
`default_nettype none

module hififo_fwft_fifo
(
   input  wire         clock,
   input  wire         reset,
   input  wire         i_write,
   input  wire  [63:0] i_data,
   output logic        o_ready,
   input  wire         i_read,
   output logic [63:0] o_data,
   output logic        o_valid,
   output logic        o_almost_empty
);
   import hififo_dma_pkg::*;
   import pcie_tlp_pkg::*;

   logic [63:0] mem [FIFO_DEPTH]; // storage, no reset
   logic [FIFO_AWIDTH-1:0] wr_ptr;
   logic [FIFO_AWIDTH-1:0] rd_ptr;
   logic [FIFO_AWIDTH:0] level; // words held, 0 to depth
   logic do_write;
   logic do_read;

   assign do_write = i_write && o_ready; // dropped when full
   assign do_read = i_read && o_valid;   // ignored when empty

   // head word is visible without a read strobe
   assign o_data = mem[rd_ptr];
   assign o_valid = level != '0;
   assign o_ready = level != (FIFO_AWIDTH + 1)'(FIFO_DEPTH);
   assign o_almost_empty = level < (FIFO_AWIDTH + 1)'(TLP_PAYLOAD_QW); // less than a packet

   always_ff @(posedge clock)
   begin
      if (do_write)
         mem[wr_ptr] <= i_data;
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level <= '0;
      end
      else
      begin
         if (do_write)
            wr_ptr <= wr_ptr + 1'b1; // wraps at depth
         if (do_read)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_write, do_read})
            2'b10:   level <= level + 1'b1;
            2'b01:   level <= level - 1'b1;
            default: level <= level; // idle or both
         endcase
      end
   end

endmodule

`default_nettype wire

/* hififo_tpc_engine.sv */
// host bound packet engine
`default_nettype none

module hififo_tpc_engine
(
   input  wire                          clock,
   input  wire                          reset,
   input  wire  [15:0]                  i_pci_id,
   input  wire                          i_req_valid,
   input  wire  hififo_dma_pkg::dma_request_t i_req,
   output logic                         o_req_ready,
   output logic [31:0]                  o_status,
   output logic                         o_interrupt,
   output logic                         o_read,
   input  wire  [63:0]                  i_data,
   input  wire                          i_almost_empty,
   output logic                         o_wr_valid,
   input  wire                          i_wr_ready,
   output pcie_tlp_pkg::tlp_beat_t      o_wr_beat
);
   import pcie_tlp_pkg::*;
   import hififo_dma_pkg::*;

   // pcie payload is little endian per dword
   function automatic logic [31:0] es(input logic [31:0] x);
      es = {x[7:0], x[15:8], x[23:16], x[31:24]};
   endfunction

   tpc_state_e state;
   logic [4:0] beat;        // index of the beat now on o_wr_beat
   logic [60:0] addr;       // qwords
   logic [18:0] count;      // qwords left in the request
   logic irq_flag;
   logic is_32;             // 3dw header for the packet in flight
   logic [31:0] held_dw;    // swapped upper dword of the last popped word
   logic [63:0] byte_addr;
   logic addr_is_32;
   logic accept;            // sink takes beat 0
   logic last_beat;
   logic [4:0] next_beat;
   logic next_last;
   logic [31:0] next_lo;
   logic [31:0] next_hi;
   tlp_hdr0_t hdr0;

   assign byte_addr = {addr, 3'b000};
   assign addr_is_32 = byte_addr[63:32] == '0;
   assign accept = (state == TPC_OFFER) && i_wr_ready;
   assign last_beat = (state == TPC_DATA) && (beat == 5'(TLP_BEATS - 1));
   assign next_beat = beat + 1'b1;
   assign next_last = next_beat == 5'(TLP_BEATS - 1);

   assign o_req_ready = count == '0;
   assign o_status = {10'd0, count, 3'd0}; // bytes left
   assign o_wr_valid = state == TPC_OFFER;

   // one pop per payload qword, 3dw pops one beat earlier for the shift
   always_comb
   begin
      if (is_32)
         o_read = accept || (state == TPC_ADDR) ||
                  ((state == TPC_DATA) && (beat < 5'(TLP_BEATS - 2)));
      else
         o_read = (state == TPC_ADDR) ||
                  ((state == TPC_DATA) && (beat < 5'(TLP_BEATS - 1)));
   end

   always_comb
   begin
      hdr0.requester_id = i_pci_id;
      hdr0.tag = 8'h00;
      hdr0.byte_en = TLP_FIRST_LAST_BE;
      hdr0.fmt_type = addr_is_32 ? TLP_FMT_MWR_3DW : TLP_FMT_MWR_4DW;
      hdr0.attr = '0;
      hdr0.length = 10'(TLP_PAYLOAD_DW);
   end

   // content of the following beat
   always_comb
   begin
      if (state == TPC_OFFER)
      begin
         // address beat, 3dw carries payload dword 0 alongside
         next_lo = is_32 ? byte_addr[31:0] : byte_addr[63:32];
         next_hi = is_32 ? es(i_data[31:0]) : byte_addr[31:0];
      end
      else if (is_32)
      begin
         next_lo = held_dw;                           // shifted by a dword
         next_hi = o_read ? es(i_data[31:0]) : 32'h0; // empty on final beat
      end
      else
      begin
         next_lo = es(i_data[31:0]);
         next_hi = es(i_data[63:32]);
      end
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         state <= TPC_IDLE;
         beat <= '0;
      end
      else
      begin
         case (state)
            TPC_IDLE:
            begin
               if ((count != '0) && !i_almost_empty) // a full packet is buffered
                  state <= TPC_OFFER;
            end
            TPC_OFFER:
            begin
               if (i_wr_ready)
               begin
                  state <= TPC_ADDR;
                  beat <= 5'd1;
               end
            end
            TPC_ADDR:
            begin
               state <= TPC_DATA;
               beat <= next_beat;
            end
            default:
            begin
               if (last_beat)
               begin
                  state <= TPC_IDLE;
                  beat <= '0;
               end
               else
                  beat <= next_beat;
            end
         endcase
      end
   end

   // beat register, header preloaded while idle
   always_ff @(posedge clock)
   begin
      if (state == TPC_IDLE)
      begin
         o_wr_beat.data <= hdr0;
         o_wr_beat.last <= 1'b0;
         o_wr_beat.last_half <= 1'b0;
         is_32 <= addr_is_32;
      end
      else if (accept || (state == TPC_ADDR) || ((state == TPC_DATA) && !last_beat))
      begin
         o_wr_beat.data <= {next_hi, next_lo};
         o_wr_beat.last <= next_last;
         o_wr_beat.last_half <= is_32 && next_last;
      end
      if (o_read)
         held_dw <= es(i_data[63:32]);
   end

   // request registers, stepped once per finished packet
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         count <= '0;
         irq_flag <= 1'b0;
         o_interrupt <= 1'b0;
      end
      else
      begin
         if (i_req_valid && o_req_ready)
         begin
            count <= i_req.count;
            irq_flag <= i_req.interrupt;
         end
         else if (last_beat)
            count <= count - 19'(TLP_PAYLOAD_QW);
         // single pulse after the final packet
         o_interrupt <= last_beat && irq_flag && (count == 19'(TLP_PAYLOAD_QW));
      end
   end

   always_ff @(posedge clock)
   begin
      if (i_req_valid && o_req_ready)
         addr <= i_req.addr;
      else if (last_beat)
         addr <= addr + 61'(TLP_PAYLOAD_QW); // 128 bytes on
   end

endmodule

`default_nettype wire

/* hififo_tpc_top.sv */
// dma write path top level
`default_nettype none

module hififo_tpc_top
(
   input  wire                          clock,
   input  wire                          reset,
   input  wire  [15:0]                  i_pci_id,
   input  wire                          i_req_valid,
   input  wire  hififo_dma_pkg::dma_request_t i_req,
   output logic                         o_req_ready,
   output logic [31:0]                  o_status,
   output logic                         o_interrupt,
   input  wire                          i_fifo_write,
   input  wire  [63:0]                  i_fifo_data,
   output logic                         o_fifo_ready,
   output logic                         o_wr_valid,
   input  wire                          i_wr_ready,
   output pcie_tlp_pkg::tlp_beat_t      o_wr_beat
);

   logic [63:0] fifo_data;   // head word
   logic fifo_read;
   logic fifo_almost_empty;  // under one packet

   hififo_fwft_fifo fifo
   (
      .clock          (clock),
      .reset          (reset),
      .i_write        (i_fifo_write),
      .i_data         (i_fifo_data),
      .o_ready        (o_fifo_ready),
      .i_read         (fifo_read),
      .o_data         (fifo_data),
      .o_valid        (),               // engine waits on a full packet instead
      .o_almost_empty (fifo_almost_empty)
   );

   hififo_tpc_engine engine
   (
      .clock          (clock),
      .reset          (reset),
      .i_pci_id       (i_pci_id),
      .i_req_valid    (i_req_valid),
      .i_req          (i_req),
      .o_req_ready    (o_req_ready),
      .o_status       (o_status),
      .o_interrupt    (o_interrupt),
      .o_read         (fifo_read),
      .i_data         (fifo_data),
      .i_almost_empty (fifo_almost_empty),
      .o_wr_valid     (o_wr_valid),
      .i_wr_ready     (i_wr_ready),
      .o_wr_beat      (o_wr_beat)
   );

endmodule

`default_nettype wire

/* hififo_tpc_properties.sv */
// engine protocol assertions
`default_nettype none

module hififo_tpc_properties
(
   input wire                          clock,
   input wire                          reset,
   input wire hififo_dma_pkg::tpc_state_e i_state,
   input wire                          i_wr_valid,
   input wire                          i_wr_ready,
   input wire                          i_read,
   input wire                          i_almost_empty,
   input wire                          i_interrupt
);
   timeunit 1ns;
   timeprecision 100ps;
   import hififo_dma_pkg::*;

   // offer stays up until the sink takes beat 0
   offer_held: assert property (@(posedge clock) disable iff (reset)
      (i_wr_valid && !i_wr_ready) |=> i_wr_valid)
      else $error("o_wr_valid dropped before acceptance");

   // no pop while under one packet during the offer
   no_short_pop: assert property (@(posedge clock) disable iff (reset)
      ((i_state == TPC_OFFER) && i_almost_empty) |-> !i_read)
      else $error("o_read with i_almost_empty in offer state");

   irq_single: assert property (@(posedge clock) disable iff (reset)
      i_interrupt |=> !i_interrupt)
      else $error("o_interrupt longer than one cycle"); // pulse only

endmodule

bind hififo_tpc_engine hififo_tpc_properties props
(
   .clock          (clock),
   .reset          (reset),
   .i_state        (state),
   .i_wr_valid     (o_wr_valid),
   .i_wr_ready     (i_wr_ready),
   .i_read         (o_read),
   .i_almost_empty (i_almost_empty),
   .i_interrupt    (o_interrupt)
);

`default_nettype wire

/* tb_hififo_tpc.sv */
// dma write engine testbench
`default_nettype none

module tb_hififo_tpc;
   timeunit 1ns;
   timeprecision 100ps;
   import pcie_tlp_pkg::*;
   import hififo_dma_pkg::*;

   typedef tlp_beat_t [TLP_BEATS-1:0] packet_t;
   typedef logic [TLP_PAYLOAD_QW-1:0][63:0] word_block_t;

   logic clock;
   logic reset;
   logic [15:0] i_pci_id;
   logic i_req_valid;
   dma_request_t i_req;
   logic o_req_ready;
   logic [31:0] o_status;
   logic o_interrupt;
   logic i_fifo_write;
   logic [63:0] i_fifo_data;
   logic o_fifo_ready;
   logic o_wr_valid;
   logic i_wr_ready;
   tlp_beat_t o_wr_beat;

   tlp_beat_t exp_q[$];      // expected beats in packet order
   logic [31:0] status_q[$]; // o_status expected at each beat 0
   logic [63:0] write_q[$];  // words generated but not yet pushed
   logic [31:0] data_rng;
   logic [31:0] ready_rng;
   logic gaps_on;            // random i_wr_ready when set
   int planned_packets = 9;  // packets over the whole run
   int exp_packets = 0;
   int rx_packets = 0;
   int irq_count = 0;
   int errors = 0;
   int test_errors = 0;
   int tests_failed = 0;
   int test_num = 0;

   hififo_tpc_top dut
   (
      .clock        (clock),
      .reset        (reset),
      .i_pci_id     (i_pci_id),
      .i_req_valid  (i_req_valid),
      .i_req        (i_req),
      .o_req_ready  (o_req_ready),
      .o_status     (o_status),
      .o_interrupt  (o_interrupt),
      .i_fifo_write (i_fifo_write),
      .i_fifo_data  (i_fifo_data),
      .o_fifo_ready (o_fifo_ready),
      .o_wr_valid   (o_wr_valid),
      .i_wr_ready   (i_wr_ready),
      .o_wr_beat    (o_wr_beat)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] state);
      logic [31:0] x;
      x = state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // byte 0 of the dword goes to byte 3
   function automatic logic [31:0] swap_dw(input logic [31:0] d);
      logic [31:0] r;
      for (int i = 0; i < 4; i++)
         r[8*i +: 8] = d[8*(3-i) +: 8];
      return r;
   endfunction

   // full 18 beat memory write for one block of 16 words
   function automatic packet_t expected_packet(input logic [15:0] pci_id,
                                               input logic [60:0] qaddr,
                                               input word_block_t words);
      logic [63:0] byte_addr;
      logic [31:0] dw [TLP_PAYLOAD_DW];
      tlp_fmt_e fmt;
      packet_t pkt;
      byte_addr = {qaddr, 3'b000};
      fmt = (byte_addr[63:32] == 32'h0) ? TLP_FMT_MWR_3DW : TLP_FMT_MWR_4DW;
      for (int k = 0; k < TLP_PAYLOAD_QW; k++)
      begin
         dw[2*k] = swap_dw(words[k][31:0]);     // even dword from low half
         dw[2*k+1] = swap_dw(words[k][63:32]);
      end
      pkt = '0;
      pkt[0].data = {pci_id, 8'h00, TLP_FIRST_LAST_BE, fmt, 14'h0, 10'(TLP_PAYLOAD_DW)};
      if (fmt == TLP_FMT_MWR_3DW)
      begin
         pkt[1].data = {dw[0], byte_addr[31:0]}; // payload starts beside the address
         for (int b = 2; b < TLP_BEATS - 1; b++)
            pkt[b].data = {dw[2*b-2], dw[2*b-3]};
         pkt[TLP_BEATS-1].data = {32'h0, dw[TLP_PAYLOAD_DW-1]};
         pkt[TLP_BEATS-1].last_half = 1'b1;
      end
      else
      begin
         pkt[1].data = {byte_addr[31:0], byte_addr[63:32]}; // high dword first
         for (int b = 2; b < TLP_BEATS; b++)
            pkt[b].data = {dw[2*b-3], dw[2*b-4]};
      end
      pkt[TLP_BEATS-1].last = 1'b1;
      return pkt;
   endfunction

   task automatic check_value(input string what, input logic [127:0] got,
                              input logic [127:0] want);
      if (got !== want)
      begin
         errors++;
         test_errors++;
         $display("[FAIL] %0t: %s, got %0h expected %0h", $time, what, got, want);
      end
   endtask

   task automatic end_test(input string name);
      test_num++;
      if (test_errors != 0)
         tests_failed++;
      $display("test %0d %s: %0d mismatches", test_num, name, test_errors);
      test_errors = 0;
   endtask

   // random words for npkt packets with their expected beats and status
   task automatic plan_packets(input logic [60:0] qaddr, input int npkt);
      word_block_t block;
      packet_t pkt;
      logic [31:0] hi;
      for (int p = 0; p < npkt; p++)
      begin
         for (int k = 0; k < TLP_PAYLOAD_QW; k++)
         begin
            data_rng = xorshift32(data_rng);
            hi = data_rng;
            data_rng = xorshift32(data_rng);
            block[k] = {hi, data_rng};
            write_q.push_back(block[k]);
         end
         pkt = expected_packet(i_pci_id, qaddr + 61'(p * TLP_PAYLOAD_QW), block);
         for (int b = 0; b < TLP_BEATS; b++)
            exp_q.push_back(pkt[b]);
         status_q.push_back(32'((npkt - p) * TLP_PAYLOAD_QW * 8)); // bytes still owed
         exp_packets++;
      end
   endtask

   task automatic write_words(input int n);
      for (int i = 0; i < n; i++)
      begin
         @(posedge clock);
         i_fifo_write <= 1'b1;
         i_fifo_data <= write_q.pop_front();
      end
      @(posedge clock);
      i_fifo_write <= 1'b0;
   endtask

   task automatic issue_request(input logic [60:0] qaddr, input int npkt, input logic irq);
      check_value("req_ready before request", 128'(o_req_ready), 128'(1));
      @(posedge clock);
      i_req_valid <= 1'b1;
      i_req <= {qaddr, 19'(npkt * TLP_PAYLOAD_QW), irq};
      @(posedge clock);
      i_req_valid <= 1'b0; // one cycle strobe
   endtask

   // all queued packets seen
   task automatic wait_done();
      while (rx_packets != exp_packets)
         @(negedge clock);
      repeat (2) @(negedge clock); // room for the interrupt pulse
   endtask

   // beats 1 to 17 follow the accepted beat 0 without gaps
   task automatic collect_packet();
      tlp_beat_t want;
      if (exp_q.size() < TLP_BEATS)
      begin
         $display("unexpected packet offered at %0t", $time);
         errors++;
         test_errors++;
         repeat (TLP_BEATS - 1) @(negedge clock);
      end
      else
      begin
         check_value($sformatf("status at packet %0d", rx_packets), 128'(o_status),
                     128'(status_q.pop_front()));
         for (int b = 0; b < TLP_BEATS; b++)
         begin
            if (b != 0)
               @(negedge clock);
            want = exp_q.pop_front();
            check_value($sformatf("packet %0d beat %0d", rx_packets, b), 128'(o_wr_beat),
                        128'(want));
         end
         rx_packets++;
      end
   endtask

   initial
   begin
      clock = 1'b0;
      forever #4 clock = ~clock;
   end

   initial
   begin : ready_driver
      i_wr_ready = 1'b1;
      ready_rng = xorshift32(32'd30103); // own stream from the shared seed
      forever
      begin
         @(posedge clock);
         ready_rng = xorshift32(ready_rng);
         i_wr_ready <= gaps_on ? (ready_rng[1:0] == 2'b00) : 1'b1; // ready one cycle in four
      end
   end

   // sampled on the falling edge where outputs are settled
   initial
   begin : beat_monitor
      tlp_beat_t held;
      logic offered;
      offered = 1'b0;
      held = '0;
      forever
      begin
         @(negedge clock);
         if (reset)
            offered = 1'b0;
         else if (o_wr_valid)
         begin
            if (offered)
               check_value("beat 0 held while stalled", 128'(o_wr_beat), 128'(held));
            if (i_wr_ready)
            begin
               offered = 1'b0;
               collect_packet();
            end
            else
            begin
               offered = 1'b1; // stalled offer repeats next cycle
               held = o_wr_beat;
            end
         end
         else if (offered)
         begin
            $display("o_wr_valid dropped at %0t before the packet was accepted", $time);
            errors++;
            test_errors++;
            offered = 1'b0;
         end
      end
   end

   initial
   begin : irq_monitor
      forever
      begin
         @(negedge clock);
         if (!reset && o_interrupt)
            irq_count++;
      end
   end

   initial
   begin : watchdog
      int limit;
      limit = planned_packets * 200 + 1000; // cycles
      repeat (limit) @(posedge clock);
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("Test failed");
      $finish;
   end

   initial
   begin : test_sequence
      int irq_base;
      int pkt_base;
      reset = 1'b1;
      i_pci_id = 16'h01a3;
      i_req_valid = 1'b0;
      i_req = '0;
      i_fifo_write = 1'b0;
      i_fifo_data = '0;
      gaps_on = 1'b0;
      data_rng = 32'd30103;
      repeat (5) @(posedge clock);
      reset <= 1'b0;
      @(negedge clock);
      check_value("wr_valid after reset", 128'(o_wr_valid), 128'(0));
      check_value("interrupt after reset", 128'(o_interrupt), 128'(0));
      check_value("req_ready after reset", 128'(o_req_ready), 128'(1));
      check_value("status after reset", 128'(o_status), 128'(0));
      check_value("fifo_ready after reset", 128'(o_fifo_ready), 128'(1));
      end_test("reset state");
      plan_packets(61'h0000_1234, 1); // below 4 GiB
      write_words(16);
      issue_request(61'h0000_1234, 1, 1'b0);
      wait_done();
      end_test("3dw header");
      plan_packets(61'h2_4000_0010, 1); // above 4 GiB
      write_words(16);
      issue_request(61'h2_4000_0010, 1, 1'b0);
      wait_done();
      end_test("4dw header");
      irq_base = irq_count;
      pkt_base = rx_packets;
      plan_packets(61'h0004_0000, 4);
      write_words(64);
      issue_request(61'h0004_0000, 4, 1'b1);
      while (rx_packets < pkt_base + 3)
         @(negedge clock);
      check_value("interrupt before last packet", 128'(irq_count - irq_base), 128'(0));
      wait_done();
      check_value("interrupt pulses", 128'(irq_count - irq_base), 128'(1));
      check_value("status after request", 128'(o_status), 128'(0));
      check_value("req_ready after request", 128'(o_req_ready), 128'(1));
      end_test("four packets with interrupt");
      gaps_on = 1'b1;
      plan_packets(61'h0000_8000, 2);
      write_words(32);
      issue_request(61'h0000_8000, 2, 1'b0);
      wait_done();
      gaps_on = 1'b0;
      end_test("ready gaps");
      plan_packets(61'h3_0000_0100, 1);
      issue_request(61'h3_0000_0100, 1, 1'b0);
      write_words(10); // short of one packet
      repeat (40)
      begin
         @(negedge clock);
         check_value("no offer below one packet", 128'(o_wr_valid), 128'(0));
      end
      write_words(6);
      wait_done();
      end_test("partial buffer");
      $display("summary: %0d tests, %0d failed, %0d errors", test_num, tests_failed, errors);
      if (errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

/* flist.f */
pcie_tlp_pkg.sv
hififo_dma_pkg.sv
hififo_fwft_fifo.sv
hififo_tpc_engine.sv
hififo_tpc_top.sv
hififo_tpc_properties.sv
tb_hififo_tpc.sv

/* run_sim.sh */
#!/bin/sh
# build and run the dma write engine testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_hififo_tpc -f flist.f -o tb_hififo_tpc
if [ $? -ne 0 ]; then
   echo "compile failed"
   exit 1
fi

./obj_dir/tb_hififo_tpc > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Test failed" sim.log; then
   exit 1
fi
exit 0
